// ==== quad_pkg.sv ====
package quad_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and lane layout
    ////////////////////////////////////////////////////////////
    localparam int pixel_w    = 16;
    localparam int num_awe    = 4;
    localparam int ce_per_awe = 2;
    localparam int num_lanes  = num_awe * ce_per_awe;
    localparam int col_w      = 9;
    localparam int seq_addr_w = 9;

    typedef logic [pixel_w-1:0]           pixel_t;
    // Lane k at bits 16k to 16k+15
    typedef logic [num_lanes*pixel_w-1:0] lane_bus_t;
    typedef logic [col_w-1:0]             col_t;
    typedef logic [seq_addr_w-1:0]        seq_addr_t;

    ////////////////////////////////////////////////////////////
    // Config and job words
    ////////////////////////////////////////////////////////////

    // One sequence table entry, column in the low bits
    typedef struct packed {
        logic [6:0] reserved;
        col_t       col;
    } seq_entry_t;

    // Only the low 9 bits of each count are used
    typedef struct packed {
        logic [15:0] num_cols;
        logic [15:0] num_entries;
    } job_params_t;

    ////////////////////////////////////////////////////////////
    // Controller FSM
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        LOAD,
        ACTIVE,
        DRAIN,
        DONE
    } ctrl_state_e;

endpackage

// ==== seq_mem.sv ====
`timescale 1ns/10ps

module seq_mem #(
    parameter int SEQ_DEPTH = 512
) (
    input  logic                 clk_if,
    input  logic                 rst,
    input  logic                 wr_en,
    input  quad_pkg::seq_entry_t wr_data,
    input  logic                 rd_en,
    input  quad_pkg::seq_addr_t  rd_addr,
    output quad_pkg::seq_entry_t rd_data
);

    localparam int addr_w = $clog2(SEQ_DEPTH);

    quad_pkg::seq_entry_t mem [SEQ_DEPTH];
    logic [addr_w-1:0]    wr_addr;

    // Host loads entries back to back from address 0
    always_ff @(posedge clk_if) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk_if) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle read, output holds while rd_en is low
    always_ff @(posedge clk_if) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr[addr_w-1:0]];
        end
    end

    // A further write would wrap onto entry 0
    assert property (@(posedge clk_if) disable iff (rst)
        wr_en |-> (wr_addr != addr_w'(SEQ_DEPTH - 1)));

endmodule

// ==== prefetch_fifo.sv ====
`timescale 1ns/10ps

module prefetch_fifo #(
    parameter int ROW_DEPTH = 512
) (
    input  logic             clk_if,
    input  logic             rst,
    input  logic             push,
    input  quad_pkg::pixel_t push_data,
    input  logic             pop,
    output quad_pkg::pixel_t pop_data,
    output logic             empty
);

    localparam int addr_w = $clog2(ROW_DEPTH);

    quad_pkg::pixel_t  mem [ROW_DEPTH];
    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   count;
    logic              full;

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_if) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_if) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Show-ahead, head word is visible before the pop
    assign pop_data = mem[rd_ptr];

    assign empty = (count == '0);
    assign full  = (count == (addr_w + 1)'(ROW_DEPTH));

    assert property (@(posedge clk_if) disable iff (rst)
        push |-> !full);

    assert property (@(posedge clk_if) disable iff (rst)
        pop |-> !empty);

endmodule

// ==== awe_rowbuffer.sv ====
`timescale 1ns/10ps

module awe_rowbuffer #(
    parameter int ROW_DEPTH = 512
) (
    input  logic                                         clk_if,
    input  logic                                         rst,
    input  logic                                         wr_en,
    input  quad_pkg::col_t                               wr_col,
    input  quad_pkg::pixel_t [quad_pkg::ce_per_awe-1:0]  wr_pixels,
    input  logic                                         rd_en,
    input  quad_pkg::col_t                               rd_col,
    output quad_pkg::pixel_t [quad_pkg::ce_per_awe-1:0]  rd_pixels
);

    localparam int addr_w = $clog2(ROW_DEPTH);

    // One row per compute lane of this engine
    quad_pkg::pixel_t row_mem [quad_pkg::ce_per_awe][ROW_DEPTH];

    ////////////////////////////////////////////////////////////
    // Row write during load
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_if) begin
        for (int lane = 0; lane < quad_pkg::ce_per_awe; lane++) begin
            if (wr_en) begin
                row_mem[lane][wr_col[addr_w-1:0]] <= wr_pixels[lane];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Column read, both lanes at the same column
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_if) begin
        for (int lane = 0; lane < quad_pkg::ce_per_awe; lane++) begin
            if (rd_en) begin
                rd_pixels[lane] <= row_mem[lane][rd_col[addr_w-1:0]];
            end
        end
    end

    // Load column must fit the row
    assert property (@(posedge clk_if) disable iff (rst)
        wr_en |-> (wr_col < ROW_DEPTH));

    // Sequence entries must name a stored column
    assert property (@(posedge clk_if) disable iff (rst)
        rd_en |-> (rd_col < ROW_DEPTH));

endmodule

// ==== quad_ctrl.sv ====
`timescale 1ns/10ps

module quad_ctrl (
    input  logic                  clk_if,
    input  logic                  rst,
    input  logic                  job_start,
    input  logic                  job_fetch_ack,
    input  logic                  job_fetch_complete,
    input  logic                  job_complete_ack,
    input  quad_pkg::job_params_t job_params,
    output logic                  job_accept,
    output logic                  job_fetch_request,
    output logic                  job_complete,
    input  logic                  pixel_valid,
    output logic                  pixel_ready,
    input  logic                  fifo_empty,
    output logic                  fifo_pop,
    output logic                  rb_wr_en,
    output quad_pkg::col_t        rb_wr_col,
    output logic                  seq_rd_en,
    output quad_pkg::seq_addr_t   seq_rd_addr,
    input  quad_pkg::seq_entry_t  seq_rd_data,
    output logic                  rb_rd_en,
    output quad_pkg::col_t        rb_rd_col,
    input  quad_pkg::lane_bus_t   rb_rd_data,
    input  logic                  result_accept,
    output logic                  result_valid,
    output quad_pkg::lane_bus_t   result_data
);

    quad_pkg::ctrl_state_e state;
    quad_pkg::job_params_t params_q;
    quad_pkg::col_t        num_cols;
    quad_pkg::seq_addr_t   num_entries;
    quad_pkg::col_t        load_col;
    quad_pkg::seq_addr_t   seq_addr;
    logic                  fetch_acked;
    logic                  more_entries;
    logic                  advance;
    logic                  s1_valid;
    logic                  s2_valid;
    logic                  pipe_empty;

    assign num_cols    = params_q.num_cols[quad_pkg::col_w-1:0];
    assign num_entries = params_q.num_entries[quad_pkg::seq_addr_w-1:0];

    ////////////////////////////////////////////////////////////
    // Job handshakes
    ////////////////////////////////////////////////////////////
    assign job_accept   = (state == quad_pkg::IDLE) && job_start;
    assign job_complete = (state == quad_pkg::DONE);
    assign pixel_ready  = (state == quad_pkg::FETCH) && fetch_acked && pixel_valid;

    always_ff @(posedge clk_if) begin
        if (job_accept) begin
            params_q <= job_params;
        end
    end

    // Request goes out the cycle after the accept
    always_ff @(posedge clk_if) begin
        if (rst) begin
            job_fetch_request <= 1'b0;
            fetch_acked       <= 1'b0;
        end else begin
            if (job_accept) begin
                job_fetch_request <= 1'b1;
            end else if (job_fetch_ack) begin
                job_fetch_request <= 1'b0;
            end
            if (job_accept) begin
                fetch_acked <= 1'b0;
            end else if (job_fetch_request && job_fetch_ack) begin
                fetch_acked <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_if) begin
        if (rst) begin
            state <= quad_pkg::IDLE;
        end else begin
            case (state)
                quad_pkg::IDLE: begin
                    if (job_start) state <= quad_pkg::FETCH;
                end
                quad_pkg::FETCH: begin
                    if (fetch_acked && job_fetch_complete) state <= quad_pkg::LOAD;
                end
                quad_pkg::LOAD: begin
                    if (fifo_empty) state <= quad_pkg::ACTIVE;
                end
                quad_pkg::ACTIVE: begin
                    if (!more_entries) state <= quad_pkg::DRAIN;
                end
                quad_pkg::DRAIN: begin
                    if (pipe_empty) state <= quad_pkg::DONE;
                end
                quad_pkg::DONE: begin
                    if (job_complete_ack) state <= quad_pkg::IDLE;
                end
                default: state <= quad_pkg::IDLE;
            endcase
        end
    end

    // Load moves one beat per cycle from all FIFOs
    assign fifo_pop  = (state == quad_pkg::LOAD) && !fifo_empty;
    assign rb_wr_en  = fifo_pop;
    assign rb_wr_col = load_col;

    always_ff @(posedge clk_if) begin
        if (rst) begin
            load_col <= '0;
            seq_addr <= '0;
        end else if (job_accept) begin
            load_col <= '0;
            seq_addr <= '0;
        end else begin
            if (fifo_pop) begin
                load_col <= load_col + 1'b1;
            end
            if (seq_rd_en) begin
                seq_addr <= seq_addr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Result pipeline of sequence read, row read and output
    ////////////////////////////////////////////////////////////
    assign advance      = !result_valid || result_accept;
    assign more_entries = (seq_addr < num_entries);
    assign seq_rd_en    = (state == quad_pkg::ACTIVE) && more_entries && advance;
    assign seq_rd_addr  = seq_addr;
    assign rb_rd_en     = advance && s1_valid;
    assign rb_rd_col    = seq_rd_data.col;
    assign pipe_empty   = !s1_valid && !s2_valid && !result_valid;

    // Whole pipeline holds when the output is stalled
    always_ff @(posedge clk_if) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else if (advance) begin
            s1_valid     <= seq_rd_en;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk_if) begin
        if (advance && s2_valid) begin
            result_data <= rb_rd_data;
        end
    end

    // Host delivers exactly num_cols beats per row
    assert property (@(posedge clk_if) disable iff (rst)
        (state == quad_pkg::LOAD && fifo_empty) |-> (load_col == num_cols));

endmodule

// ==== cnn_quad.sv ====
`timescale 1ns/10ps

module cnn_quad #(
    parameter int ROW_DEPTH = 512,
    parameter int SEQ_DEPTH = 512
) (
    input  logic                  clk_if,
    input  logic                  rst,
    // Job port
    input  logic                  job_start,
    output logic                  job_accept,
    input  quad_pkg::job_params_t job_params,
    output logic                  job_fetch_request,
    input  logic                  job_fetch_ack,
    input  logic                  job_fetch_complete,
    output logic                  job_complete,
    input  logic                  job_complete_ack,
    // Config port
    input  logic                  config_valid,
    output logic                  config_accept,
    input  quad_pkg::seq_entry_t  config_data,
    // Pixel port
    input  logic                  pixel_valid,
    output logic                  pixel_ready,
    input  quad_pkg::lane_bus_t   pixel_data,
    // Result port
    output logic                  result_valid,
    input  logic                  result_accept,
    output quad_pkg::lane_bus_t   result_data
);

    localparam int pair_w = quad_pkg::ce_per_awe * quad_pkg::pixel_w;

    logic                              fifo_push;
    logic                              fifo_pop;
    wire  [quad_pkg::num_lanes-1:0]    fifo_empty;
    wire  quad_pkg::lane_bus_t         fifo_data;
    logic                              rb_wr_en;
    quad_pkg::col_t                    rb_wr_col;
    logic                              rb_rd_en;
    quad_pkg::col_t                    rb_rd_col;
    wire  quad_pkg::lane_bus_t         rb_rd_data;
    logic                              seq_wr_en;
    logic                              seq_rd_en;
    quad_pkg::seq_addr_t               seq_rd_addr;
    quad_pkg::seq_entry_t              seq_rd_data;

    ////////////////////////////////////////////////////////////
    // Config capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_if) begin
        if (rst) begin
            config_accept <= 1'b0;
        end else begin
            config_accept <= config_valid;
        end
    end

    assign seq_wr_en = config_valid && config_accept;

    seq_mem #(
        .SEQ_DEPTH (SEQ_DEPTH)
    ) u_seq_mem (
        .clk_if  (clk_if),
        .rst     (rst),
        .wr_en   (seq_wr_en),
        .wr_data (config_data),
        .rd_en   (seq_rd_en),
        .rd_addr (seq_rd_addr),
        .rd_data (seq_rd_data)
    );

    ////////////////////////////////////////////////////////////
    // Per lane FIFOs and per engine row buffers
    ////////////////////////////////////////////////////////////
    assign fifo_push = pixel_valid && pixel_ready;

    for (genvar lane = 0; lane < quad_pkg::num_lanes; lane++) begin : g_fifo
        prefetch_fifo #(
            .ROW_DEPTH (ROW_DEPTH)
        ) u_fifo (
            .clk_if    (clk_if),
            .rst       (rst),
            .push      (fifo_push),
            .push_data (pixel_data[lane*quad_pkg::pixel_w +: quad_pkg::pixel_w]),
            .pop       (fifo_pop),
            .pop_data  (fifo_data[lane*quad_pkg::pixel_w +: quad_pkg::pixel_w]),
            .empty     (fifo_empty[lane])
        );
    end

    // Engine e serves lanes 2e and 2e+1
    for (genvar awe = 0; awe < quad_pkg::num_awe; awe++) begin : g_awe
        awe_rowbuffer #(
            .ROW_DEPTH (ROW_DEPTH)
        ) u_rowbuffer (
            .clk_if    (clk_if),
            .rst       (rst),
            .wr_en     (rb_wr_en),
            .wr_col    (rb_wr_col),
            .wr_pixels (fifo_data[awe*pair_w +: pair_w]),
            .rd_en     (rb_rd_en),
            .rd_col    (rb_rd_col),
            .rd_pixels (rb_rd_data[awe*pair_w +: pair_w])
        );
    end

    quad_ctrl u_ctrl (
        .clk_if             (clk_if),
        .rst                (rst),
        .job_start          (job_start),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete_ack   (job_complete_ack),
        .job_params         (job_params),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_complete       (job_complete),
        .pixel_valid        (pixel_valid),
        .pixel_ready        (pixel_ready),
        .fifo_empty         (fifo_empty[0]),
        .fifo_pop           (fifo_pop),
        .rb_wr_en           (rb_wr_en),
        .rb_wr_col          (rb_wr_col),
        .seq_rd_en          (seq_rd_en),
        .seq_rd_addr        (seq_rd_addr),
        .seq_rd_data        (seq_rd_data),
        .rb_rd_en           (rb_rd_en),
        .rb_rd_col          (rb_rd_col),
        .rb_rd_data         (rb_rd_data),
        .result_accept      (result_accept),
        .result_valid       (result_valid),
        .result_data        (result_data)
    );

    // Controller watches lane 0 only, so all lanes must agree
    assert property (@(posedge clk_if) disable iff (rst)
        fifo_empty == {quad_pkg::num_lanes{fifo_empty[0]}});

endmodule

// ==== tb_cnn_quad.sv ====
`timescale 1ns/10ps

module tb_cnn_quad;

    localparam int wait_limit = 200;
    localparam int stim_depth = 64;

    // Record types, low nibble of each stim line
    localparam logic [3:0] tag_end = 4'h0;
    localparam logic [3:0] tag_cfg = 4'h1;
    localparam logic [3:0] tag_job = 4'h2;
    localparam logic [3:0] tag_pix = 4'h3;
    localparam logic [3:0] tag_exp = 4'h4;
    localparam logic [3:0] tag_bp  = 4'h5;

    logic                  clk_if;
    logic                  rst;
    logic                  job_start;
    logic                  job_accept;
    quad_pkg::job_params_t job_params;
    logic                  job_fetch_request;
    logic                  job_fetch_ack;
    logic                  job_fetch_complete;
    logic                  job_complete;
    logic                  job_complete_ack;
    logic                  config_valid;
    logic                  config_accept;
    quad_pkg::seq_entry_t  config_data;
    logic                  pixel_valid;
    logic                  pixel_ready;
    quad_pkg::lane_bus_t   pixel_data;
    logic                  result_valid;
    logic                  result_accept;
    quad_pkg::lane_bus_t   result_data;

    logic [131:0]          stim [stim_depth];
    integer                seed;
    logic                  bp_on;
    string                 cur_test;
    int                    test_errs;
    int                    tests_run;
    int                    tests_failed;
    int                    total_errs;
    logic                  fetch_open;
    logic                  job_open;
    logic                  held_valid;
    quad_pkg::lane_bus_t   held_data;

    cnn_quad #(
        .ROW_DEPTH (64),
        .SEQ_DEPTH (64)
    ) UUT (
        .clk_if             (clk_if),
        .rst                (rst),
        .job_start          (job_start),
        .job_accept         (job_accept),
        .job_params         (job_params),
        .job_fetch_request  (job_fetch_request),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete       (job_complete),
        .job_complete_ack   (job_complete_ack),
        .config_valid       (config_valid),
        .config_accept      (config_accept),
        .config_data        (config_data),
        .pixel_valid        (pixel_valid),
        .pixel_ready        (pixel_ready),
        .pixel_data         (pixel_data),
        .result_valid       (result_valid),
        .result_accept      (result_accept),
        .result_data        (result_data)
    );

    initial begin
        clk_if = 1'b0;
        forever #50 clk_if = ~clk_if;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s expected %h actual %h", cur_test, what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout in %s, %s never arrived", cur_test, what);
        $display("=== FAIL ===");
        $finish;
    endtask

    // Drive point just after the rising edge
    task automatic next_cycle();
        int rnd;
        @(posedge clk_if);
        #5;
        if (bp_on) begin
            rnd = $random(seed);
            result_accept = rnd[0];
        end else begin
            result_accept = 1'b1;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %-12s ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", cur_test, test_errs);
        end
    endtask

    // A word held back by the host must not move
    task automatic check_stall();
        if (held_valid) begin
            check_value("held result_valid", 1, result_valid);
            check_value("held result_data", held_data, result_data);
        end
        held_valid = result_valid && !result_accept;
        held_data  = result_data;
    endtask

    ////////////////////////////////////////////////////////////
    // Port sequences
    ////////////////////////////////////////////////////////////
    task automatic send_config(input quad_pkg::seq_entry_t entry);
        int n;
        config_valid = 1'b1;
        config_data  = entry;
        n = 0;
        @(negedge clk_if);
        while (!config_accept) begin
            n++;
            if (n >= wait_limit) timeout_fail("config_accept");
            @(negedge clk_if);
        end
        next_cycle();
    endtask

    task automatic start_job(input logic [127:0] payload);
        int n;
        job_params = payload[31:0];
        job_start  = 1'b1;
        n = 0;
        @(negedge clk_if);
        while (!job_accept) begin
            n++;
            if (n >= wait_limit) timeout_fail("job_accept");
            @(negedge clk_if);
        end
        next_cycle();
        job_start = 1'b0;
        n = 0;
        @(negedge clk_if);
        while (!job_fetch_request) begin
            n++;
            if (n >= wait_limit) timeout_fail("job_fetch_request");
            @(negedge clk_if);
        end
        next_cycle();
        job_fetch_ack = 1'b1;
        next_cycle();
        job_fetch_ack = 1'b0;
        check_value("job_fetch_request after ack", 0, job_fetch_request);
        fetch_open = 1'b1;
    endtask

    task automatic send_pixels(input quad_pkg::lane_bus_t beat);
        int n;
        pixel_valid = 1'b1;
        pixel_data  = beat;
        n = 0;
        @(negedge clk_if);
        while (!pixel_ready) begin
            n++;
            if (n >= wait_limit) timeout_fail("pixel_ready");
            @(negedge clk_if);
        end
        next_cycle();
    endtask

    task automatic end_fetch();
        pixel_valid        = 1'b0;
        job_fetch_complete = 1'b1;
        next_cycle();
        job_fetch_complete = 1'b0;
        fetch_open         = 1'b0;
    endtask

    task automatic take_result(input quad_pkg::lane_bus_t expected);
        int   n;
        logic taken;
        n     = 0;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk_if);
            check_stall();
            if (result_valid && result_accept) begin
                check_value("result_data", expected, result_data);
                taken = 1'b1;
            end else begin
                n++;
                if (n >= wait_limit) timeout_fail("result_valid");
            end
            next_cycle();
        end
    endtask

    task automatic finish_job();
        int n;
        n = 0;
        @(negedge clk_if);
        while (!job_complete) begin
            check_stall();
            check_value("extra result_valid", 0, result_valid);
            n++;
            if (n >= wait_limit) timeout_fail("job_complete");
            @(negedge clk_if);
        end
        // Completion holds while the host is slow to ack
        repeat (3) begin
            next_cycle();
            @(negedge clk_if);
            check_value("job_complete before ack", 1, job_complete);
        end
        next_cycle();
        job_complete_ack = 1'b1;
        next_cycle();
        job_complete_ack = 1'b0;
        @(negedge clk_if);
        check_value("job_complete after ack", 0, job_complete);
        next_cycle();
        job_open = 1'b0;
        end_test();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int           idx;
        int           job_count;
        logic [3:0]   tag;
        logic [127:0] payload;

        seed               = 12051;
        rst                = 1'b1;
        job_start          = 1'b0;
        job_params         = '0;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack   = 1'b0;
        config_valid       = 1'b0;
        config_data        = '0;
        pixel_valid        = 1'b0;
        pixel_data         = '0;
        result_accept      = 1'b1;
        bp_on              = 1'b0;
        tests_run          = 0;
        tests_failed       = 0;
        total_errs         = 0;
        fetch_open         = 1'b0;
        job_open           = 1'b0;
        held_valid         = 1'b0;
        held_data          = '0;
        job_count          = 0;
        for (idx = 0; idx < stim_depth; idx++) begin
            stim[idx] = '0;
        end
        $readmemh("quad_stim.txt", stim);

        repeat (2) @(posedge clk_if);
        #5;
        rst = 1'b0;

        start_test("reset_state");
        @(negedge clk_if);
        check_value("job_accept", 0, job_accept);
        check_value("job_fetch_request", 0, job_fetch_request);
        check_value("job_complete", 0, job_complete);
        check_value("config_accept", 0, config_accept);
        check_value("pixel_ready", 0, pixel_ready);
        check_value("result_valid", 0, result_valid);
        end_test();
        next_cycle();

        idx = 0;
        while (idx < stim_depth && stim[idx][3:0] != tag_end) begin
            tag     = stim[idx][3:0];
            payload = stim[idx][131:4];
            // Close whichever phase this record ends
            if (tag != tag_cfg && config_valid) begin
                config_valid = 1'b0;
                end_test();
            end
            if (tag != tag_pix && fetch_open) begin
                end_fetch();
            end
            if (job_open && tag != tag_pix && tag != tag_exp) begin
                finish_job();
            end
            case (tag)
                tag_cfg: begin
                    if (!config_valid) start_test("config_load");
                    send_config(payload[15:0]);
                end
                tag_job: begin
                    job_count++;
                    start_test($sformatf("job_%0d%s", job_count, bp_on ? "_bp" : ""));
                    held_valid = 1'b0;
                    start_job(payload);
                    job_open = 1'b1;
                end
                tag_pix: send_pixels(payload);
                tag_exp: take_result(payload);
                tag_bp:  bp_on = payload[0];
                default: begin
                    $display("Unknown record type %h on stim line %0d", tag, idx);
                    total_errs++;
                end
            endcase
            idx++;
        end
        if (config_valid) begin
            config_valid = 1'b0;
            end_test();
        end
        if (fetch_open) end_fetch();
        if (job_open) finish_job();
        if (job_count == 0) begin
            $display("The stimulus file held no job");
            total_errs++;
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (tests_failed == 0 && total_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== quad_stim.txt ====
// Each line is a hex payload followed by one digit of record type
// 1 CFG entry, 2 JOB cols and entries, 3 PIX beat, 4 EXP result, 5 BP on or off
// Sequence table, columns 1 3 0 2 4
11
31
01
21
41
// Job 1, 4 columns and 4 entries
000400042
700060005000400030002000100000003
700160015001400130012001100100013
700260025002400230022002100200023
700360035003400330032003100300033
700160015001400130012001100100014
700360035003400330032003100300034
700060005000400030002000100000004
700260025002400230022002100200024
// Job 2 under random back-pressure, 5 columns and 5 entries
15
000500052
7B006B005B004B003B002B001B000B003
7B016B015B014B013B012B011B010B013
7B026B025B024B023B022B021B020B023
7B036B035B034B033B032B031B030B033
7B046B045B044B043B042B041B040B043
7B016B015B014B013B012B011B010B014
7B036B035B034B033B032B031B030B034
7B006B005B004B003B002B001B000B004
7B026B025B024B023B022B021B020B024
7B046B045B044B043B042B041B040B044

// ==== src.f ====
quad_pkg.sv
seq_mem.sv
prefetch_fifo.sv
awe_rowbuffer.sv
quad_ctrl.sv
cnn_quad.sv
tb_cnn_quad.sv

// ==== Bender.yml ====
package:
  name: cnn_quad

sources:
  - files:
      - quad_pkg.sv
      - seq_mem.sv
      - prefetch_fifo.sv
      - awe_rowbuffer.sv
      - quad_ctrl.sv
      - cnn_quad.sv
  - target: test
    files:
      - tb_cnn_quad.sv
